/* verilog/sched_pkg.sv */
package sched_pkg;

  localparam int HASH_WIDTH = 32;

  typedef logic [HASH_WIDTH-1:0] hash_t;

  // Core control word has the message type on top and the slot number at the bottom
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int CTRL_WIDTH     = 16;

  typedef enum logic [MSG_TYPE_WIDTH-1:0] {
    MSG_SLOT_RETURN = 4'd0,
    MSG_SLOT_INIT   = 4'd3
  } ctrl_msg_e;

  // Host register map, address taken from host_cmd[29:27]
  typedef enum logic [2:0] {
    HOST_INCOME_CORES = 3'd0,
    HOST_SLOT_COUNT   = 3'd2,
    HOST_DROP_COUNT   = 3'd7
  } host_addr_e;

  localparam int          HOST_WR_BIT = 31;
  localparam logic [31:0] RD_DEFAULT  = 32'hFEFE_FEFE;

endpackage

/* verilog/pkt_stream_if.sv */
`timescale 1ns/1ns

interface pkt_stream_if #(
  parameter int DATA_WIDTH = 64,
  parameter int DEST_WIDTH = 6
);

  logic [DATA_WIDTH-1:0]   data;
  logic [DATA_WIDTH/8-1:0] keep;
  logic                    last;
  logic [DEST_WIDTH-1:0]   dest;
  logic                    valid;
  logic                    ready;

  modport src (output data, keep, last, dest, valid, input ready);
  modport snk (input data, keep, last, dest, valid, output ready);

endinterface

/* verilog/flow_hash.sv */
`timescale 1ns/1ns

module flow_hash import sched_pkg::*; #(
  parameter int DATA_WIDTH = 64
) (
  input  logic      clk,
  input  logic      rst_r,
  pkt_stream_if.snk rx,
  output hash_t     hash,
  output logic      hash_valid
);

  localparam int WORD_COUNT = DATA_WIDTH / HASH_WIDTH;

  logic  first_beat;
  logic  beat_ok;
  hash_t fold;
  hash_t fold_r;

  assign beat_ok = rx.valid && rx.ready;

  // XOR of all 32-bit words of the beat on the bus
  always_comb begin
    fold = '0;
    for (int i = 0; i < WORD_COUNT; i++) begin
      fold = fold ^ rx.data[i*HASH_WIDTH +: HASH_WIDTH];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      first_beat <= 1'b1;
      hash_valid <= 1'b0;
    end else begin
      hash_valid <= beat_ok && rx.last;
      if (beat_ok) begin
        first_beat <= rx.last;
      end
    end
  end

  // Only the first beat counts, single-beat packets take the fold directly
  always_ff @(posedge clk) begin
    if (beat_ok && first_beat) begin
      fold_r <= fold;
    end
    if (beat_ok && rx.last) begin
      hash <= first_beat ? fold : fold_r;
    end
  end

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [PTR_WIDTH-1:0]       wr_ptr;
  logic [PTR_WIDTH-1:0]       rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       push;
  logic                       pop;

  assign in_ready  = (count != DEPTH);
  assign out_valid = (count != 0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

/* verilog/slot_pool.sv */
`timescale 1ns/1ns

module slot_pool import sched_pkg::*; #(
  parameter int  CORE_COUNT    = 4,
  parameter int  SLOT_COUNT    = 8,
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1)
) (
  input  logic                     clk,
  input  logic                     rst_r,
  input  logic [CTRL_WIDTH-1:0]    ctrl_tdata,
  input  logic [CORE_ID_WIDTH-1:0] ctrl_tuser,
  input  logic                     ctrl_tvalid,
  output logic [CORE_COUNT-1:0]    slot_avail,
  input  logic [CORE_ID_WIDTH-1:0] pop_core,
  input  logic                     slot_pop,
  output logic [SLOT_WIDTH-1:0]    head_slot,
  input  logic [CORE_ID_WIDTH-1:0] count_core,
  output logic [SLOT_WIDTH-1:0]    slot_count
);

  localparam int PTR_WIDTH = $clog2(SLOT_COUNT);

  logic [SLOT_WIDTH-1:0]     slots [CORE_COUNT][SLOT_COUNT];
  logic [PTR_WIDTH-1:0]      head [CORE_COUNT];
  logic [PTR_WIDTH-1:0]      tail [CORE_COUNT];
  logic [SLOT_WIDTH-1:0]     free [CORE_COUNT];
  logic [MSG_TYPE_WIDTH-1:0] msg_type;
  logic [SLOT_WIDTH-1:0]     msg_slot;
  logic [SLOT_WIDTH-1:0]     init_n;
  logic [CORE_COUNT-1:0]     init_hit;
  logic [CORE_COUNT-1:0]     ret_hit;
  logic [CORE_COUNT-1:0]     pop_hit;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(SLOT_COUNT - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign msg_type = ctrl_tdata[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH];
  assign msg_slot = ctrl_tdata[SLOT_WIDTH-1:0];
  // An init larger than the list is clamped
  assign init_n   = (msg_slot > SLOT_COUNT) ? SLOT_WIDTH'(SLOT_COUNT) : msg_slot;

  always_comb begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      init_hit[c]   = ctrl_tvalid && (ctrl_tuser == c) && (msg_type == MSG_SLOT_INIT);
      ret_hit[c]    = ctrl_tvalid && (ctrl_tuser == c) && (msg_type == MSG_SLOT_RETURN)
                      && (free[c] != SLOT_COUNT);
      pop_hit[c]    = slot_pop && (pop_core == c) && (free[c] != 0);
      slot_avail[c] = (free[c] != 0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        head[c] <= '0;
        tail[c] <= '0;
        free[c] <= '0;
      end
    end else begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (init_hit[c]) begin
          head[c] <= '0;
          tail[c] <= (init_n == SLOT_COUNT) ? '0 : PTR_WIDTH'(init_n);
          free[c] <= init_n;
        end else begin
          if (ret_hit[c]) begin
            tail[c] <= next_ptr(tail[c]);
          end
          if (pop_hit[c]) begin
            head[c] <= next_ptr(head[c]);
          end
          if (ret_hit[c] && !pop_hit[c]) begin
            free[c] <= free[c] + 1'b1;
          end else if (pop_hit[c] && !ret_hit[c]) begin
            free[c] <= free[c] - 1'b1;
          end
        end
      end
    end
  end

  // Init fills the whole ring with 1..SLOT_COUNT, only the first n are live
  always_ff @(posedge clk) begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (init_hit[c]) begin
        for (int s = 0; s < SLOT_COUNT; s++) begin
          slots[c][s] <= SLOT_WIDTH'(s + 1);
        end
      end else if (ret_hit[c]) begin
        slots[c][tail[c]] <= msg_slot;
      end
    end
  end

  assign head_slot  = slots[pop_core][head[pop_core]];
  assign slot_count = free[count_core];

endmodule

/* verilog/desc_allocator.sv */
`timescale 1ns/1ns

module desc_allocator import sched_pkg::*; #(
  parameter int  CORE_COUNT    = 4,
  parameter int  SLOT_COUNT    = 8,
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int DESC_WIDTH    = 1 + HASH_WIDTH + CORE_ID_WIDTH + SLOT_WIDTH
) (
  input  logic                     clk,
  input  logic                     rst_r,
  input  hash_t                    hash,
  input  logic                     hash_valid,
  output logic                     hash_ready,
  input  logic [CORE_COUNT-1:0]    income_cores,
  input  logic                     rx_almost_full,
  input  logic [CORE_COUNT-1:0]    slot_avail,
  output logic [CORE_ID_WIDTH-1:0] pop_core,
  output logic                     slot_pop,
  input  logic [SLOT_WIDTH-1:0]    head_slot,
  output logic [DESC_WIDTH-1:0]    desc_data,
  output logic                     desc_valid,
  input  logic                     desc_ready,
  output logic [31:0]              drop_count
);

  typedef enum logic {
    ALLOC_IDLE,
    ALLOC_DECIDE
  } alloc_state_e;

  alloc_state_e             state;
  logic [CORE_ID_WIDTH-1:0] core_r;
  logic                     take;
  logic                     drop;

  // Deliver when the core accepts and has a slot, else drop only under rx pressure
  assign take = (state == ALLOC_DECIDE) && income_cores[core_r] && slot_avail[core_r]
                && desc_ready;
  assign drop = (state == ALLOC_DECIDE) && !take && rx_almost_full && desc_ready;

  assign pop_core   = core_r;
  assign slot_pop   = take;
  assign hash_ready = take || drop;
  assign desc_valid = take || drop;
  assign desc_data  = {drop, hash, core_r, head_slot};

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state      <= ALLOC_IDLE;
      drop_count <= '0;
    end else begin
      case (state)
        ALLOC_IDLE: begin
          if (hash_valid) begin
            state <= ALLOC_DECIDE;
          end
        end
        default: begin
          if (take || drop) begin
            state <= ALLOC_IDLE;
          end
          if (drop) begin
            drop_count <= drop_count + 1'b1;
          end
        end
      endcase
    end
  end

  // Low hash bits pick the core
  always_ff @(posedge clk) begin
    if (state == ALLOC_IDLE) begin
      core_r <= hash[CORE_ID_WIDTH-1:0];
    end
  end

endmodule

/* verilog/hash_prepend.sv */
`timescale 1ns/1ns

module hash_prepend import sched_pkg::*; #(
  parameter int  DATA_WIDTH    = 64,
  parameter int  CORE_COUNT    = 4,
  parameter int  SLOT_COUNT    = 8,
  localparam int KEEP_WIDTH    = DATA_WIDTH / 8,
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1),
  localparam int DEST_WIDTH    = CORE_ID_WIDTH + SLOT_WIDTH,
  localparam int DESC_WIDTH    = 1 + HASH_WIDTH + DEST_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic [DESC_WIDTH-1:0] desc_data,
  input  logic                  desc_valid,
  output logic                  desc_ready,
  pkt_stream_if.snk             pkt,
  pkt_stream_if.src             tx
);

  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    BODY,
    DISCARD
  } state_e;

  state_e                state;
  logic                  desc_drop;
  hash_t                 desc_hash;
  logic [DEST_WIDTH-1:0] desc_dest;
  logic                  pkt_end;

  // Descriptor stays at the fifo head until its packet is done
  assign {desc_drop, desc_hash, desc_dest} = desc_data;
  assign pkt_end    = pkt.valid && pkt.ready && pkt.last;
  assign desc_ready = pkt_end;

  always_comb begin
    tx.data   = pkt.data;
    tx.keep   = pkt.keep;
    tx.last   = pkt.last;
    tx.dest   = desc_dest;
    tx.valid  = 1'b0;
    pkt.ready = 1'b0;
    case (state)
      HEADER: begin
        // Hash in the low 4 bytes only
        tx.data  = DATA_WIDTH'(desc_hash);
        tx.keep  = KEEP_WIDTH'(4'hF);
        tx.last  = 1'b0;
        tx.valid = 1'b1;
      end
      BODY: begin
        tx.valid  = pkt.valid;
        pkt.ready = tx.ready;
      end
      DISCARD: begin
        pkt.ready = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (desc_valid) begin
            state <= desc_drop ? DISCARD : HEADER;
          end
        end
        HEADER: begin
          if (tx.ready) begin
            state <= BODY;
          end
        end
        default: begin
          if (pkt_end) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* verilog/host_regs.sv */
`timescale 1ns/1ns

module host_regs import sched_pkg::*; #(
  parameter int  CORE_COUNT    = 4,
  parameter int  SLOT_COUNT    = 8,
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT),
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1)
) (
  input  logic                     clk,
  input  logic                     rst_r,
  input  logic [31:0]              host_cmd,
  input  logic [31:0]              host_cmd_wr_data,
  input  logic                     host_cmd_valid,
  output logic [31:0]              host_cmd_rd_data,
  output logic [CORE_COUNT-1:0]    income_cores,
  output logic [CORE_ID_WIDTH-1:0] count_core,
  input  logic [SLOT_WIDTH-1:0]    slot_count,
  input  logic [31:0]              drop_count
);

  logic [31:0] cmd_r;
  logic [31:0] wr_data_r;
  logic        valid_r;
  logic [2:0]  addr;

  assign addr       = cmd_r[29:27];
  assign count_core = cmd_r[CORE_ID_WIDTH-1:0];

  always_ff @(posedge clk) begin
    cmd_r     <= host_cmd;
    wr_data_r <= host_cmd_wr_data;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      valid_r      <= 1'b0;
      income_cores <= '0;
    end else begin
      valid_r <= host_cmd_valid;
      if (valid_r && cmd_r[HOST_WR_BIT] && (addr == HOST_INCOME_CORES)) begin
        income_cores <= wr_data_r[CORE_COUNT-1:0];
      end
    end
  end

  // Read-back follows the registered address, valid or not
  always_ff @(posedge clk) begin
    case (addr)
      HOST_INCOME_CORES: host_cmd_rd_data <= 32'(income_cores);
      HOST_SLOT_COUNT:   host_cmd_rd_data <= 32'(slot_count);
      HOST_DROP_COUNT:   host_cmd_rd_data <= drop_count;
      default:           host_cmd_rd_data <= RD_DEFAULT;
    endcase
  end

endmodule

/* verilog/flow_sched_top.sv */
`timescale 1ns/1ns

module flow_sched_top import sched_pkg::*; #(
  parameter int  DATA_WIDTH      = 64,
  parameter int  CORE_COUNT      = 4,
  parameter int  SLOT_COUNT      = 8,
  parameter int  DATA_FIFO_DEPTH = 64,
  parameter int  DESC_FIFO_DEPTH = 8,
  localparam int KEEP_WIDTH      = DATA_WIDTH / 8,
  localparam int CORE_ID_WIDTH   = $clog2(CORE_COUNT),
  localparam int SLOT_WIDTH      = $clog2(SLOT_COUNT + 1),
  localparam int DEST_WIDTH      = CORE_ID_WIDTH + SLOT_WIDTH
) (
  input  logic                     clk,
  input  logic                     rst_r,
  input  logic [DATA_WIDTH-1:0]    rx_tdata,
  input  logic [KEEP_WIDTH-1:0]    rx_tkeep,
  input  logic                     rx_tlast,
  input  logic                     rx_tvalid,
  output logic                     rx_tready,
  input  logic                     rx_almost_full,
  output logic [DATA_WIDTH-1:0]    tx_tdata,
  output logic [KEEP_WIDTH-1:0]    tx_tkeep,
  output logic [DEST_WIDTH-1:0]    tx_tdest,
  output logic                     tx_tlast,
  output logic                     tx_tvalid,
  input  logic                     tx_tready,
  input  logic [CTRL_WIDTH-1:0]    ctrl_tdata,
  input  logic [CORE_ID_WIDTH-1:0] ctrl_tuser,
  input  logic                     ctrl_tvalid,
  output logic                     ctrl_tready,
  input  logic [31:0]              host_cmd,
  input  logic [31:0]              host_cmd_wr_data,
  input  logic                     host_cmd_valid,
  output logic [31:0]              host_cmd_rd_data
);

  localparam int DESC_WIDTH = 1 + HASH_WIDTH + DEST_WIDTH;
  localparam int BEAT_WIDTH = DATA_WIDTH + KEEP_WIDTH + 1;

  pkt_stream_if #(.DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH)) rx_if ();
  pkt_stream_if #(.DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH)) pkt_if ();
  pkt_stream_if #(.DATA_WIDTH(DATA_WIDTH), .DEST_WIDTH(DEST_WIDTH)) tx_if ();

  hash_t                    hash;
  logic                     hash_valid;
  logic                     hash_in_ready;
  hash_t                    hash_f;
  logic                     hash_f_valid;
  logic                     hash_f_ready;
  logic                     data_in_ready;
  logic [DESC_WIDTH-1:0]    desc_in;
  logic                     desc_in_valid;
  logic                     desc_in_ready;
  logic [DESC_WIDTH-1:0]    desc_out;
  logic                     desc_out_valid;
  logic                     desc_out_ready;
  logic [CORE_COUNT-1:0]    slot_avail;
  logic [CORE_ID_WIDTH-1:0] pop_core;
  logic                     slot_pop;
  logic [SLOT_WIDTH-1:0]    head_slot;
  logic [CORE_ID_WIDTH-1:0] count_core;
  logic [SLOT_WIDTH-1:0]    slot_count;
  logic [CORE_COUNT-1:0]    income_cores;
  logic [31:0]              drop_count;

  // A beat is taken only when both the data and the hash fifo have room
  assign rx_if.data   = rx_tdata;
  assign rx_if.keep   = rx_tkeep;
  assign rx_if.last   = rx_tlast;
  assign rx_if.dest   = '0;
  assign rx_if.valid  = rx_tvalid;
  assign rx_if.ready  = data_in_ready && hash_in_ready;
  assign rx_tready    = rx_if.ready;
  assign pkt_if.dest  = '0;
  assign tx_tdata     = tx_if.data;
  assign tx_tkeep     = tx_if.keep;
  assign tx_tdest     = tx_if.dest;
  assign tx_tlast     = tx_if.last;
  assign tx_tvalid    = tx_if.valid;
  assign tx_if.ready  = tx_tready;
  assign ctrl_tready  = 1'b1;

  flow_hash #(.DATA_WIDTH(DATA_WIDTH)) flow_hash_inst (
    .clk        (clk),
    .rst_r      (rst_r),
    .rx         (rx_if.snk),
    .hash       (hash),
    .hash_valid (hash_valid)
  );

  sync_fifo #(.WIDTH(BEAT_WIDTH), .DEPTH(DATA_FIFO_DEPTH)) data_fifo (
    .clk       (clk),
    .rst_r     (rst_r),
    .in_data   ({rx_if.data, rx_if.keep, rx_if.last}),
    .in_valid  (rx_if.valid && hash_in_ready),
    .in_ready  (data_in_ready),
    .out_data  ({pkt_if.data, pkt_if.keep, pkt_if.last}),
    .out_valid (pkt_if.valid),
    .out_ready (pkt_if.ready)
  );

  sync_fifo #(.WIDTH(HASH_WIDTH), .DEPTH(DESC_FIFO_DEPTH)) hash_fifo (
    .clk       (clk),
    .rst_r     (rst_r),
    .in_data   (hash),
    .in_valid  (hash_valid),
    .in_ready  (hash_in_ready),
    .out_data  (hash_f),
    .out_valid (hash_f_valid),
    .out_ready (hash_f_ready)
  );

  sync_fifo #(.WIDTH(DESC_WIDTH), .DEPTH(DESC_FIFO_DEPTH)) desc_fifo (
    .clk       (clk),
    .rst_r     (rst_r),
    .in_data   (desc_in),
    .in_valid  (desc_in_valid),
    .in_ready  (desc_in_ready),
    .out_data  (desc_out),
    .out_valid (desc_out_valid),
    .out_ready (desc_out_ready)
  );

  slot_pool #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) slot_pool_inst (
    .clk         (clk),
    .rst_r       (rst_r),
    .ctrl_tdata  (ctrl_tdata),
    .ctrl_tuser  (ctrl_tuser),
    .ctrl_tvalid (ctrl_tvalid),
    .slot_avail  (slot_avail),
    .pop_core    (pop_core),
    .slot_pop    (slot_pop),
    .head_slot   (head_slot),
    .count_core  (count_core),
    .slot_count  (slot_count)
  );

  desc_allocator #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) desc_allocator_inst (
    .clk            (clk),
    .rst_r          (rst_r),
    .hash           (hash_f),
    .hash_valid     (hash_f_valid),
    .hash_ready     (hash_f_ready),
    .income_cores   (income_cores),
    .rx_almost_full (rx_almost_full),
    .slot_avail     (slot_avail),
    .pop_core       (pop_core),
    .slot_pop       (slot_pop),
    .head_slot      (head_slot),
    .desc_data      (desc_in),
    .desc_valid     (desc_in_valid),
    .desc_ready     (desc_in_ready),
    .drop_count     (drop_count)
  );

  hash_prepend #(
    .DATA_WIDTH (DATA_WIDTH),
    .CORE_COUNT (CORE_COUNT),
    .SLOT_COUNT (SLOT_COUNT)
  ) hash_prepend_inst (
    .clk        (clk),
    .rst_r      (rst_r),
    .desc_data  (desc_out),
    .desc_valid (desc_out_valid),
    .desc_ready (desc_out_ready),
    .pkt        (pkt_if.snk),
    .tx         (tx_if.src)
  );

  host_regs #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) host_regs_inst (
    .clk              (clk),
    .rst_r            (rst_r),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data),
    .income_cores     (income_cores),
    .count_core       (count_core),
    .slot_count       (slot_count),
    .drop_count       (drop_count)
  );

endmodule

/* verif/tb_flow_sched.sv */
`timescale 1ns/1ns

module tb_flow_sched import sched_pkg::*;;

  localparam int DATA_WIDTH = 64;
  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 8;
  localparam int DEST_WIDTH = 6;
  localparam logic [31:0] SEED = 32'd10964;

  // Cycle budget per test, the watchdog allows four times the sum
  localparam int TEST_CYCLES = 80 + 80 + 300 + 400 + 300 + 1000;
  localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;
  localparam int RX_WAIT_LIMIT = 300;
  localparam int TX_WAIT_LIMIT = 600;

  typedef struct packed {
    logic [63:0]           data;
    logic [7:0]            keep;
    logic                  last;
    logic [DEST_WIDTH-1:0] dest;
  } beat_t;

  logic        clk = 1'b0;
  logic        rst_r;
  logic [63:0] rx_tdata;
  logic [7:0]  rx_tkeep;
  logic        rx_tlast;
  logic        rx_tvalid;
  logic        rx_tready;
  logic        rx_almost_full;
  logic [63:0] tx_tdata;
  logic [7:0]  tx_tkeep;
  logic [DEST_WIDTH-1:0] tx_tdest;
  logic        tx_tlast;
  logic        tx_tvalid;
  logic        tx_tready = 1'b1;
  logic [15:0] ctrl_tdata;
  logic [1:0]  ctrl_tuser;
  logic        ctrl_tvalid;
  logic        ctrl_tready;
  logic [31:0] host_cmd;
  logic [31:0] host_cmd_wr_data;
  logic        host_cmd_valid;
  logic [31:0] host_cmd_rd_data;

  logic [31:0] rng = SEED;
  logic [31:0] ready_rng = SEED;
  logic        bp_enable = 1'b0;
  int          mismatches = 0;
  int          timeouts = 0;

  // Reference model state
  int          free_list [CORE_COUNT][$];
  logic [63:0] cur_data [$];
  logic [7:0]  cur_keep [$];
  beat_t       exp_beats [$];
  int          exp_len [$];
  beat_t       got_beats [$];

  flow_sched_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .CORE_COUNT (CORE_COUNT),
    .SLOT_COUNT (SLOT_COUNT)
  ) dut0 (
    .clk              (clk),
    .rst_r            (rst_r),
    .rx_tdata         (rx_tdata),
    .rx_tkeep         (rx_tkeep),
    .rx_tlast         (rx_tlast),
    .rx_tvalid        (rx_tvalid),
    .rx_tready        (rx_tready),
    .rx_almost_full   (rx_almost_full),
    .tx_tdata         (tx_tdata),
    .tx_tkeep         (tx_tkeep),
    .tx_tdest         (tx_tdest),
    .tx_tlast         (tx_tlast),
    .tx_tvalid        (tx_tvalid),
    .tx_tready        (tx_tready),
    .ctrl_tdata       (ctrl_tdata),
    .ctrl_tuser       (ctrl_tuser),
    .ctrl_tvalid      (ctrl_tvalid),
    .ctrl_tready      (ctrl_tready),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Flow hash is the XOR of the two 32-bit words of the first beat
  function automatic logic [31:0] fold_hash(input logic [63:0] d);
    return d[31:0] ^ d[63:32];
  endfunction

  // Random tx back-pressure while enabled
  always @(posedge clk) begin
    if (bp_enable) begin
      ready_rng = lcg_next(ready_rng);
      tx_tready <= ready_rng[20];
    end else begin
      tx_tready <= 1'b1;
    end
  end

  always @(negedge clk) begin
    if (!rst_r && tx_tvalid && tx_tready) begin
      got_beats.push_back(beat_t'({tx_tdata, tx_tkeep, tx_tlast, tx_tdest}));
    end
  end

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic host_write(input logic [2:0] addr, input logic [31:0] data);
    @(posedge clk);
    host_cmd <= {1'b1, 1'b0, addr, 27'd0};
    host_cmd_wr_data <= data;
    host_cmd_valid <= 1'b1;
    @(posedge clk);
    host_cmd_valid <= 1'b0;
    @(posedge clk);
  endtask

  // Read-back is valid two edges after the address is driven
  task automatic host_read(input logic [2:0] addr, input int core, output logic [31:0] val);
    @(posedge clk);
    host_cmd <= {1'b0, 1'b0, addr, 27'(core)};
    repeat (2) @(posedge clk);
    @(negedge clk);
    val = host_cmd_rd_data;
  endtask

  task automatic slot_msg(input int core, input ctrl_msg_e msg, input int value);
    @(posedge clk);
    ctrl_tdata <= {msg, 12'(value)};
    ctrl_tuser <= 2'(core);
    ctrl_tvalid <= 1'b1;
    if (msg == MSG_SLOT_INIT) begin
      free_list[core].delete();
      for (int s = 1; s <= value && s <= SLOT_COUNT; s++) begin
        free_list[core].push_back(s);
      end
    end else if (msg == MSG_SLOT_RETURN && free_list[core].size() < SLOT_COUNT) begin
      free_list[core].push_back(value);
    end
    // Control stream is always ready
    @(negedge clk);
    if (ctrl_tready !== 1'b1) begin
      report_mismatch("ctrl_tready low while a control word is offered");
    end
    @(posedge clk);
    ctrl_tvalid <= 1'b0;
  endtask

  // Random beats, first word steered so the hash selects the core
  task automatic make_packet(input int core, input int nbeats);
    logic [63:0] w;
    logic [31:0] h;
    cur_data.delete();
    cur_keep.delete();
    for (int i = 0; i < nbeats; i++) begin
      rng = lcg_next(rng);
      w[31:0] = rng;
      rng = lcg_next(rng);
      w[63:32] = rng;
      cur_data.push_back(w);
      cur_keep.push_back(8'hFF);
    end
    w = cur_data[0];
    h = fold_hash(w);
    w[1:0] = w[1:0] ^ h[1:0] ^ 2'(core);
    cur_data[0] = w;
    rng = lcg_next(rng);
    cur_keep[nbeats-1] = 8'hFF >> rng[18:16];
  endtask

  // Header beat then payload, dest is core above the next free slot
  task automatic queue_expected(input int core);
    beat_t b;
    int    slot;
    slot = free_list[core].pop_front();
    b.data = {32'h0, fold_hash(cur_data[0])};
    b.keep = 8'h0F;
    b.last = 1'b0;
    b.dest = {2'(core), 4'(slot)};
    exp_beats.push_back(b);
    for (int i = 0; i < cur_data.size(); i++) begin
      b.data = cur_data[i];
      b.keep = cur_keep[i];
      b.last = (i == cur_data.size() - 1);
      exp_beats.push_back(b);
    end
    exp_len.push_back(cur_data.size() + 1);
  endtask

  task automatic send_packet();
    int waited;
    for (int i = 0; i < cur_data.size(); i++) begin
      @(posedge clk);
      rx_tdata <= cur_data[i];
      rx_tkeep <= cur_keep[i];
      rx_tlast <= (i == cur_data.size() - 1);
      rx_tvalid <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!rx_tready && waited < RX_WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (!rx_tready) begin
        timeouts++;
        $display("Timed out at %0t ns waiting for rx_tready", $time);
        rx_tvalid <= 1'b0;
        return;
      end
    end
    @(posedge clk);
    rx_tvalid <= 1'b0;
  endtask

  task automatic expect_packet();
    int    len;
    int    waited;
    beat_t g;
    beat_t e;
    waited = 0;
    while ((exp_len.size() == 0 || got_beats.size() < exp_len[0])
           && waited < TX_WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_len.size() == 0 || got_beats.size() < exp_len[0]) begin
      timeouts++;
      $display("Timed out at %0t ns waiting for a packet on tx", $time);
      return;
    end
    len = exp_len.pop_front();
    for (int i = 0; i < len; i++) begin
      g = got_beats.pop_front();
      e = exp_beats.pop_front();
      if (g !== e) begin
        report_mismatch($sformatf("tx beat %0d got %h/%h/%b/%h expected %h/%h/%b/%h",
          i, g.data, g.keep, g.last, g.dest, e.data, e.keep, e.last, e.dest));
      end
    end
  endtask

  task automatic expect_idle(input int cycles);
    repeat (cycles) @(posedge clk);
    if (got_beats.size() != 0) begin
      report_mismatch($sformatf("%0d unexpected beats on tx", got_beats.size()));
      got_beats.delete();
    end
  endtask

  // Polls the drop counter until it reaches the expected value
  task automatic check_drop_count(input int expected);
    logic [31:0] val;
    int          tries;
    tries = 0;
    host_read(HOST_DROP_COUNT, 0, val);
    while (val != expected && tries < 20) begin
      host_read(HOST_DROP_COUNT, 0, val);
      tries++;
    end
    if (val !== expected) begin
      report_mismatch($sformatf("drop count %0d, expected %0d", val, expected));
    end
  endtask

  task automatic test_host_regs();
    logic [31:0] val;
    host_write(HOST_INCOME_CORES, 32'h5);
    host_read(HOST_INCOME_CORES, 0, val);
    if (val !== 32'h5) begin
      report_mismatch($sformatf("income cores read %h, expected 5", val));
    end
    host_read(3'd1, 0, val);
    if (val !== 32'hFEFE_FEFE) begin
      report_mismatch($sformatf("unmapped address 1 read %h", val));
    end
    host_read(3'd5, 0, val);
    if (val !== 32'hFEFE_FEFE) begin
      report_mismatch($sformatf("unmapped address 5 read %h", val));
    end
  endtask

  task automatic test_slot_setup();
    logic [31:0] val;
    slot_msg(2, MSG_SLOT_INIT, 5);
    host_read(HOST_SLOT_COUNT, 2, val);
    if (val !== 32'(free_list[2].size())) begin
      report_mismatch($sformatf("core 2 slot count %0d after init", val));
    end
    slot_msg(2, MSG_SLOT_RETURN, 6);
    host_read(HOST_SLOT_COUNT, 2, val);
    if (val !== 32'(free_list[2].size())) begin
      report_mismatch($sformatf("core 2 slot count %0d after return", val));
    end
  endtask

  // Core 2 is allowed, two packets take slots 1 and 2
  task automatic test_kept_packet();
    for (int i = 0; i < 2; i++) begin
      make_packet(2, 3);
      queue_expected(2);
      send_packet();
      expect_packet();
    end
  endtask

  // Core 1 has free slots but is not allowed, so only the income bit forces the drop
  task automatic test_drop();
    rx_almost_full <= 1'b1;
    slot_msg(1, MSG_SLOT_INIT, 2);
    for (int i = 1; i <= 2; i++) begin
      make_packet(1, 2 + i);
      send_packet();
      check_drop_count(i);
    end
    expect_idle(30);
  endtask

  task automatic test_wait_then_deliver();
    rx_almost_full <= 1'b0;
    slot_msg(3, MSG_SLOT_INIT, 4);
    make_packet(3, 2);
    queue_expected(3);
    send_packet();
    expect_idle(40);
    host_write(HOST_INCOME_CORES, 32'hF);
    expect_packet();
  endtask

  task automatic test_backpressure();
    for (int c = 0; c < CORE_COUNT; c++) begin
      slot_msg(c, MSG_SLOT_INIT, SLOT_COUNT);
    end
    bp_enable <= 1'b1;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          int core;
          rng = lcg_next(rng);
          core = int'(rng[17:16]);
          make_packet(core, 1 + int'(rng[21:20]));
          queue_expected(core);
          send_packet();
        end
      end
      begin
        for (int i = 0; i < 8; i++) begin
          expect_packet();
        end
      end
    join
    bp_enable <= 1'b0;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst_r = 1'b1;
    rx_tdata = '0;
    rx_tkeep = '0;
    rx_tlast = 1'b0;
    rx_tvalid = 1'b0;
    rx_almost_full = 1'b0;
    ctrl_tdata = '0;
    ctrl_tuser = '0;
    ctrl_tvalid = 1'b0;
    host_cmd = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid = 1'b0;
    repeat (16) @(posedge clk);
    rst_r <= 1'b0;
    test_host_regs();
    test_slot_setup();
    test_kept_packet();
    test_drop();
    test_wait_then_deliver();
    test_backpressure();
    expect_idle(20);
    $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
verilog/sched_pkg.sv
verilog/pkt_stream_if.sv
verilog/flow_hash.sv
verilog/sync_fifo.sv
verilog/slot_pool.sv
verilog/desc_allocator.sv
verilog/hash_prepend.sv
verilog/host_regs.sv
verilog/flow_sched_top.sv
verif/tb_flow_sched.sv

/* Makefile */
# Verilator build and run for the flow scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_flow_sched
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
JOBS      ?= 4

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
